// ==== project.f ====
+incdir+source
+incdir+test
source/tinyCorePkg.sv
source/itemQueue.sv
source/regFile.sv
source/insnFetch.sv
source/execUnit.sv
source/tinyCoreTop.sv
test/tinyCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tinyCoreTb
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== test/coreRefModel.svh ====
`ifndef CORE_REF_MODEL_SVH
`define CORE_REF_MODEL_SVH

// Word fields MSB first: top bit, type, deref, Z, X, Y, op, I
function automatic logic [31:0] encodeInsn(input logic immIsY, input logic [1:0] deref,
        input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
        input opcode_t op, input logic [11:0] imm);
    return {1'b0, immIsY, deref, z, x, y, op, imm};
endfunction

function automatic logic [31:0] signExt12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

// Expected ALU output for operands a and b
function automatic logic [31:0] aluRef(input opcode_t op, input logic [31:0] a,
        input logic [31:0] b);
    logic [31:0] r;
    case (op)
        OP_OR:    r = a | b;
        OP_AND:   r = a & b;
        OP_ADD:   r = a + b;
        OP_MUL:   r = a * b;
        OP_SHL:   r = (b > 32'd31) ? 32'd0 : (a << b[4:0]);
        OP_CMPLE: r = ($signed(a) <= $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
        OP_CMPEQ: r = (a == b) ? 32'hFFFF_FFFF : 32'd0;
        OP_NOR:   r = ~(a | b);
        OP_NAND:  r = ~(a & b);
        OP_XOR:   r = a ^ b;
        OP_SUB:   r = a - b;
        OP_XNOR:  r = ~(a ^ b);
        OP_SHR:   r = (b > 32'd31) ? 32'd0 : (a >> b[4:0]);  // Unsigned
        OP_CMPGT: r = ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
        OP_CMPNE: r = (a != b) ? 32'hFFFF_FFFF : 32'd0;
        default:  r = 32'd0;
    endcase
    return r;
endfunction

// Type 0 is (X op Y) + I, type 1 is (X op I) + Y
function automatic logic [31:0] rhsRef(input opcode_t op, input logic immIsY,
        input logic [31:0] xv, input logic [31:0] yv, input logic [11:0] imm);
    if (immIsY) begin
        return aluRef(op, xv, signExt12(imm)) + yv;
    end
    return aluRef(op, xv, yv) + signExt12(imm);
endfunction

`endif

// ==== test/tinyCoreTb.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tinyCoreConsts.svh"

module tinyCoreTb import tinyCorePkg::*; ();

    localparam int ROM_WORDS = 128;

    logic        clk;
    logic        _reset;
    logic [31:0] o_insnAddr;
    logic [31:0] i_insnData;
    logic        o_storeValid;
    storeReq_t   o_store;
    logic        i_storeReady;
    logic        o_halted;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] romOffset;
    int          romLen = 0;
    logic [31:0] modelRegs [16];
    bit          live = 1'b1;      // Cleared for words a jump skips
    storeReq_t   expStores [$];
    string       expNames [$];
    int          seed = 45;

    `include "coreRefModel.svh"

    tinyCoreTop DUT (
        .clk(clk), ._reset(_reset),
        .o_insnAddr(o_insnAddr), .i_insnData(i_insnData),
        .o_storeValid(o_storeValid), .o_store(o_store), .i_storeReady(i_storeReady),
        .o_halted(o_halted)
    );

    // Combinational program ROM with the halt word past the end
    always_comb begin
        romOffset = o_insnAddr - `RESET_VECTOR;
        if (romOffset < romLen) begin
            i_insnData = rom[romOffset[6:0]];
        end else begin
            i_insnData = `HALT_WORD;
        end
    end

    task automatic failRun();
        $display("Simulation FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    function automatic logic [31:0] readModel(input logic [3:0] idx, input logic [31:0] pc);
        if (idx == 4'd0) begin
            return 32'd0;
        end
        if (idx == `PC_INDEX) begin
            return pc + 32'd1;
        end
        return modelRegs[idx];
    endfunction

    // Append one word and run it on the model unless skipped
    task automatic emit(input string name, input logic immIsY, input logic [1:0] deref,
            input logic [3:0] z, input logic [3:0] x, input logic [3:0] y,
            input opcode_t op, input logic [11:0] imm);
        logic [31:0] pc;
        logic [31:0] rhs;
        storeReq_t   req;
        pc = `RESET_VECTOR + romLen;
        rom[romLen] = encodeInsn(immIsY, deref, z, x, y, op, imm);
        romLen++;
        if (live) begin
            rhs = rhsRef(op, immIsY, readModel(x, pc), readModel(y, pc), imm);
            if (deref == 2'b00 && z != 4'd0 && z != `PC_INDEX) begin
                modelRegs[z] = rhs;
            end else if (deref[1]) begin
                req.addr = deref[0] ? readModel(z, pc) : rhs;
                req.data = deref[0] ? rhs : readModel(z, pc);
                expStores.push_back(req);
                expNames.push_back(name);
            end
        end
    endtask

    task automatic buildProgram();
        opcode_t op;
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = 32'd0;
        end
        emit("load r1", 1'b0, 2'b00, 4'd1, 4'd0, 4'd0, OP_OR, 12'h5A3);
        emit("load r2", 1'b0, 2'b00, 4'd2, 4'd0, 4'd0, OP_OR, 12'h007);
        emit("load r3", 1'b0, 2'b00, 4'd3, 4'd0, 4'd0, OP_OR, 12'hFEC);  // -20
        for (int k = 0; k < 16; k++) begin
            if (k != 4) begin
                op = opcode_t'(k);
                emit($sformatf("%s type 0", op.name()), 1'b0, 2'b11, `PC_INDEX,
                     4'd1, 4'd2, op, 12'h011);
                emit($sformatf("%s type 1", op.name()), 1'b1, 2'b11, `PC_INDEX,
                     4'd3, 4'd2, op, 12'h004);
            end
        end
        emit("CMPEQ true", 1'b1, 2'b11, `PC_INDEX, 4'd2, 4'd1, OP_CMPEQ, 12'h007);
        emit("CMPGT signed", 1'b0, 2'b11, `PC_INDEX, 4'd1, 4'd3, OP_CMPGT, 12'h000);
        emit("jump", 1'b0, 2'b00, `PC_INDEX, `PC_INDEX, 4'd0, OP_OR, 12'h003);
        live = 1'b0;
        for (int s = 0; s < 3; s++) begin
            emit("skipped store", 1'b0, 2'b11, `PC_INDEX, 4'd1, 4'd2, OP_ADD, 12'h7AB);
        end
        live = 1'b1;
        emit("write r0", 1'b0, 2'b00, 4'd0, 4'd1, 4'd0, OP_OR, 12'h005);
        emit("r0 reads zero", 1'b0, 2'b10, 4'd0, 4'd1, 4'd0, OP_OR, 12'h000);
        rom[romLen] = `HALT_WORD;
        romLen++;
    endtask

    task automatic checkIdle(input string phase);
        assert (!o_storeValid && !o_halted) else begin
            $display("Store valid or halt is high during %s", phase);
            failRun();
        end
        assert (o_insnAddr == `RESET_VECTOR) else begin
            $display("[ERROR] %s: expected %h, actual %h", phase, `RESET_VECTOR, o_insnAddr);
            failRun();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random store-ready sink that checks each accepted store
    initial begin : storeSink
        int        r;
        bit        stallPending;
        storeReq_t heldStore;
        storeReq_t expected;
        string     name;
        i_storeReady = 1'b0;
        stallPending = 1'b0;
        forever begin
            @(negedge clk);
            r = $random(seed);
            i_storeReady = r[0];
            #1;
            if (stallPending) begin
                assert (o_storeValid && o_store == heldStore) else begin
                    $display("Stalled store was dropped or changed before acceptance");
                    failRun();
                end
            end
            if (o_storeValid && i_storeReady) begin
                assert (expStores.size() > 0) else begin
                    $display("Unexpected store of %h to address %h", o_store.data, o_store.addr);
                    failRun();
                end
                expected = expStores.pop_front();
                name = expNames.pop_front();
                assert (o_store == expected) else begin
                    $display("[ERROR] %s: expected addr %h data %h, actual addr %h data %h",
                             name, expected.addr, expected.data, o_store.addr, o_store.data);
                    failRun();
                end
            end
            stallPending = o_storeValid && !i_storeReady;
            heldStore = o_store;
        end
    end

    initial begin : watchdog
        int limit;
        #1;
        limit = romLen * 40 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", limit);
        failRun();
    end

    initial begin
        _reset = 1'b0;
        buildProgram();
        repeat (10) begin
            @(negedge clk);
            checkIdle("reset");
        end
        _reset = 1'b1;
        #1;
        checkIdle("first cycle after reset");

        while (!o_halted) @(negedge clk);
        while (expStores.size() > 0) @(negedge clk);
        repeat (50) begin
            @(negedge clk);
            assert (o_halted && !o_storeValid) else begin
                $display("Halt dropped or an extra store appeared after the last expected one");
                failRun();
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/tinyCoreTop.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tinyCoreConsts.svh"

module tinyCoreTop import tinyCorePkg::*; (
    input  wire logic  clk,
    input  wire logic  _reset,
    output word_t      o_insnAddr,
    input  wire word_t i_insnData,
    output logic       o_storeValid,
    output storeReq_t  o_store,
    input  wire logic  i_storeReady,
    output logic       o_halted
);

    logic         fetchValid, fetchReady;
    decodedInsn_t fetchItem;
    logic         insnValid, insnReady;
    decodedInsn_t insnItem;
    logic         storeValid, storeReady;
    storeReq_t    storeItem;
    logic         redirect;
    word_t        target;
    regIndex_t    readX, readY, readZ, writeIndex;
    word_t        valueX, valueY, valueZ, writeData;
    logic         writeEnable;

    insnFetch fetch (
        .clk(clk), ._reset(_reset),
        .i_redirect(redirect), .i_target(target), .i_halted(o_halted),
        .o_insnAddr(o_insnAddr), .i_insnData(i_insnData),
        .o_valid(fetchValid), .o_item(fetchItem), .i_ready(fetchReady)
    );

    itemQueue #(.payload_t(decodedInsn_t), .DEPTH(`INSN_QUEUE_DEPTH)) insnQueue (
        .clk(clk), ._reset(_reset), .i_flush(redirect),
        .i_valid(fetchValid), .i_data(fetchItem), .o_ready(fetchReady),
        .o_valid(insnValid), .o_data(insnItem), .i_ready(insnReady)
    );

    // Main copy serves X and Y
    regFile regs (
        .clk(clk), ._reset(_reset),
        .i_readX(readX), .i_readY(readY), .i_writeIndex(writeIndex),
        .o_valueX(valueX), .o_valueY(valueY),
        .i_writeEnable(writeEnable), .i_writeData(writeData)
    );

    // Mirror written in lockstep gives the Z read for stores
    regFile zRegs (
        .clk(clk), ._reset(_reset),
        .i_readX(readZ), .i_readY(4'd0), .i_writeIndex(writeIndex),
        .o_valueX(valueZ), .o_valueY(),
        .i_writeEnable(writeEnable), .i_writeData(writeData)
    );

    execUnit exec (
        .clk(clk), ._reset(_reset),
        .i_valid(insnValid), .i_insn(insnItem), .o_ready(insnReady),
        .o_readX(readX), .o_readY(readY), .o_readZ(readZ),
        .i_valueX(valueX), .i_valueY(valueY), .i_valueZ(valueZ),
        .o_writeIndex(writeIndex), .o_writeEnable(writeEnable), .o_writeData(writeData),
        .o_storeValid(storeValid), .o_store(storeItem), .i_storeReady(storeReady),
        .o_redirect(redirect), .o_target(target), .o_halted(o_halted)
    );

    itemQueue #(.payload_t(storeReq_t), .DEPTH(`STORE_QUEUE_DEPTH)) storeQueue (
        .clk(clk), ._reset(_reset), .i_flush(1'b0),
        .i_valid(storeValid), .i_data(storeItem), .o_ready(storeReady),
        .o_valid(o_storeValid), .o_data(o_store), .i_ready(i_storeReady)
    );

endmodule

`default_nettype wire

// ==== source/execUnit.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tinyCoreConsts.svh"

module execUnit import tinyCorePkg::*; (
    input  wire logic         clk,
    input  wire logic         _reset,
    input  wire logic         i_valid,
    input  wire decodedInsn_t i_insn,
    output logic              o_ready,
    output regIndex_t         o_readX,
    output regIndex_t         o_readY,
    output regIndex_t         o_readZ,
    input  wire word_t        i_valueX,
    input  wire word_t        i_valueY,
    input  wire word_t        i_valueZ,
    output regIndex_t         o_writeIndex,
    output logic              o_writeEnable,
    output word_t             o_writeData,
    output logic              o_storeValid,
    output storeReq_t         o_store,
    input  wire logic         i_storeReady,
    output logic              o_redirect,
    output word_t             o_target,
    output logic              o_halted
);

    logic  halted;
    logic  transfer;
    logic  storesNow;
    logic  writesZ;
    word_t nextPc;
    word_t xVal, yVal, zVal;
    word_t immExt, opB, addend, aluOut, rhs;

    assign o_readX = i_insn.x;
    assign o_readY = i_insn.y;
    assign o_readZ = i_insn.z;

    // R15 reads as the address of the following instruction
    assign nextPc = i_insn.pc + 32'd1;
    assign xVal = (i_insn.x == `PC_INDEX) ? nextPc : i_valueX;
    assign yVal = (i_insn.y == `PC_INDEX) ? nextPc : i_valueY;
    assign zVal = (i_insn.z == `PC_INDEX) ? nextPc : i_valueZ;

    assign immExt = {{20{i_insn.imm[11]}}, i_insn.imm};
    assign opB    = i_insn.immIsY ? immExt : yVal;  // Type 1 swaps I and Y
    assign addend = i_insn.immIsY ? yVal : immExt;

    always_comb begin
        case (i_insn.op)
            OP_OR:    aluOut = xVal | opB;
            OP_AND:   aluOut = xVal & opB;
            OP_ADD:   aluOut = xVal + opB;
            OP_MUL:   aluOut = xVal * opB;  // Low word only
            OP_SHL:   aluOut = xVal << opB;
            OP_CMPLE: aluOut = {32{$signed(xVal) <= $signed(opB)}};
            OP_CMPEQ: aluOut = {32{xVal == opB}};
            OP_NOR:   aluOut = ~(xVal | opB);
            OP_NAND:  aluOut = ~(xVal & opB);
            OP_XOR:   aluOut = xVal ^ opB;
            OP_SUB:   aluOut = xVal - opB;
            OP_XNOR:  aluOut = xVal ^ ~opB;
            OP_SHR:   aluOut = xVal >> opB;  // Logical shift
            OP_CMPGT: aluOut = {32{$signed(xVal) > $signed(opB)}};
            OP_CMPNE: aluOut = {32{xVal != opB}};
            default:  aluOut = '0;           // Reserved, flagged illegal
        endcase
    end

    assign rhs = aluOut + addend;

    assign storesNow = i_insn.deref[1] && !i_insn.illegal;
    assign writesZ   = (i_insn.deref == 2'b00) && !i_insn.illegal;

    // Stall only when a store has nowhere to go
    assign o_ready  = !halted && (!storesNow || i_storeReady);
    assign transfer = i_valid && o_ready;

    // Deref 10 puts Z at [rhs], deref 11 puts rhs at [Z]
    assign o_storeValid = i_valid && !halted && storesNow;
    assign o_store.addr = i_insn.deref[0] ? zVal : rhs;
    assign o_store.data = i_insn.deref[0] ? rhs : zVal;

    assign o_writeIndex  = i_insn.z;
    assign o_writeEnable = transfer && writesZ && (i_insn.z != `PC_INDEX);
    assign o_writeData   = rhs;

    assign o_redirect = transfer && writesZ && (i_insn.z == `PC_INDEX);  // Jump
    assign o_target   = rhs;

    always_ff @(posedge clk) begin
        if (!_reset) begin
            halted <= 1'b0;
        end else if (transfer && i_insn.illegal) begin
            halted <= 1'b1;  // Sticky until reset
        end
    end

    assign o_halted = halted;

endmodule

`default_nettype wire

// ==== source/insnFetch.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tinyCoreConsts.svh"

module insnFetch import tinyCorePkg::*; (
    input  wire logic         clk,
    input  wire logic         _reset,
    input  wire logic         i_redirect,
    input  wire word_t        i_target,
    input  wire logic         i_halted,
    output word_t             o_insnAddr,
    input  wire word_t        i_insnData,
    output logic              o_valid,
    output decodedInsn_t      o_item,
    input  wire logic         i_ready
);

    word_t     pc;
    insnWord_t word;
    logic      badDeref;
    logic      badOp;

    assign word = i_insnData;
    assign o_insnAddr = pc;

    // Loads are not supported, so deref 01 is rejected here
    assign badDeref = (word.deref == 2'b01);
    assign badOp    = (word.op == OP_RSVD);

    always_comb begin
        o_item.pc      = pc;
        o_item.deref   = word.deref;
        o_item.immIsY  = word.immIsY;
        o_item.z       = word.z;
        o_item.x       = word.x;
        o_item.y       = word.y;
        o_item.op      = word.op;
        o_item.imm     = word.imm;
        o_item.illegal = (i_insnData == `HALT_WORD) || badDeref || badOp;
    end

    // Nothing pushed in the redirect cycle, the queue is being flushed
    assign o_valid = !i_halted && !i_redirect;

    always_ff @(posedge clk) begin
        if (!_reset) begin
            pc <= `RESET_VECTOR;
        end else if (i_redirect) begin
            pc <= i_target;  // Restart at jump target
        end else if (o_valid && i_ready) begin
            pc <= pc + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tinyCoreConsts.svh"

module regFile import tinyCorePkg::*; (
    input  wire logic      clk,
    input  wire logic      _reset,
    input  wire regIndex_t i_readX,
    input  wire regIndex_t i_readY,
    input  wire regIndex_t i_writeIndex,
    output word_t          o_valueX,
    output word_t          o_valueY,
    input  wire logic      i_writeEnable,
    input  wire word_t     i_writeData
);

    word_t regs [1:14];  // R0 is constant, R15 lives in the PC

    // Index 0 and the PC index both read zero here
    function automatic word_t readReg(input regIndex_t idx);
        if (idx == 4'd0 || idx == `PC_INDEX) begin
            return '0;
        end
        return regs[idx];
    endfunction

    assign o_valueX = readReg(i_readX);
    assign o_valueY = readReg(i_readY);

    always_ff @(posedge clk) begin
        if (!_reset) begin
            for (int i = 1; i <= 14; i++) begin
                regs[i] <= '0;
            end
        end else if (i_writeEnable && i_writeIndex != 4'd0 && i_writeIndex != `PC_INDEX) begin
            regs[i_writeIndex] <= i_writeData;
        end
    end

endmodule

`default_nettype wire

// ==== source/itemQueue.sv ====
`default_nettype none
`timescale 1ns/100ps

module itemQueue import tinyCorePkg::*; #(
    parameter type payload_t = word_t,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk,
    input  wire logic     _reset,
    input  wire logic     i_flush,
    input  wire logic     i_valid,
    input  wire payload_t i_data,
    output logic          o_ready,
    output logic          o_valid,
    output payload_t      o_data,
    input  wire logic     i_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic       push;
    logic       pop;

    assign o_ready = (count != CNT_W'(DEPTH));
    assign o_valid = (count != '0);
    assign o_data  = mem[rdPtr];

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push && !i_flush) begin
            mem[wrPtr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!_reset || i_flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/tinyCorePkg.sv ====
`default_nettype none

package tinyCorePkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIndex_t;

    // Right-hand side operations, encoded as in the instruction word
    typedef enum logic [3:0] {
        OP_OR    = 4'b0000,
        OP_AND   = 4'b0001,
        OP_ADD   = 4'b0010,
        OP_MUL   = 4'b0011,
        OP_RSVD  = 4'b0100,  // Reserved, illegal
        OP_SHL   = 4'b0101,
        OP_CMPLE = 4'b0110,
        OP_CMPEQ = 4'b0111,
        OP_NOR   = 4'b1000,
        OP_NAND  = 4'b1001,
        OP_XOR   = 4'b1010,
        OP_SUB   = 4'b1011,
        OP_XNOR  = 4'b1100,
        OP_SHR   = 4'b1101,
        OP_CMPGT = 4'b1110,
        OP_CMPNE = 4'b1111
    } opcode_t;

    // Raw instruction word, MSB first
    typedef struct packed {
        logic        topBit;   // Only set in the halt word
        logic        immIsY;   // Type bit
        logic [1:0]  deref;
        regIndex_t   z;
        regIndex_t   x;
        regIndex_t   y;
        opcode_t     op;
        logic [11:0] imm;
    } insnWord_t;

    typedef struct packed {
        word_t       pc;
        logic [1:0]  deref;
        logic        immIsY;
        regIndex_t   z;
        regIndex_t   x;
        regIndex_t   y;
        opcode_t     op;
        logic [11:0] imm;
        logic        illegal;
    } decodedInsn_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } storeReq_t;

endpackage

`default_nettype wire

// ==== source/tinyCoreConsts.svh ====
`ifndef TINY_CORE_CONSTS_SVH
`define TINY_CORE_CONSTS_SVH

// First fetch address after reset
`define RESET_VECTOR 32'h0000_1000

// Entry counts of the two queues
`define INSN_QUEUE_DEPTH 4
`define STORE_QUEUE_DEPTH 4

// Register number that aliases the program counter
`define PC_INDEX 4'd15

// All-ones word, decoded as illegal, ends a program
`define HALT_WORD 32'hFFFF_FFFF

`endif
